/* src/conv_config.svh */
// conv engine configuration
// data widths, kernel size and map size limits

`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// --------------------
// data widths
`define PIXEL_W 8
`define WEIGHT_W 8
`define ACC_W 20    // 9 taps of 8x8 products plus sign

// --------------------
// geometry
`define K_DIM 3
`define MAX_MAP_DIM 16

// write-back clamp
`define RES_MAX 127

`endif

/* src/conv_data_pkg.sv */
// conv data types
// map pixels, kernel weights and dot-product sums

`include "conv_config.svh"

package conv_data_pkg;

  // map and result values
  typedef logic signed [`PIXEL_W-1:0] pixel_t;

  // kernel taps
  typedef logic signed [`WEIGHT_W-1:0] weight_t;

  // sum over one 3x3 patch
  typedef logic signed [`ACC_W-1:0] acc_t;

endpackage

/* src/conv_geom_pkg.sv */
// conv geometry types
// buffer addresses, side lengths and stride code

`include "conv_config.svh"

package conv_geom_pkg;

  // map and result buffer index, row-major
  typedef logic [$clog2(`MAX_MAP_DIM*`MAX_MAP_DIM)-1:0] map_addr_t;

  // kernel buffer index
  typedef logic [$clog2(`K_DIM*`K_DIM)-1:0] tap_addr_t;

  // side length, one spare bit so MAX_MAP_DIM fits
  typedef logic [$clog2(`MAX_MAP_DIM):0] dim_t;

  typedef logic stride_t;   // 0 stride 1, 1 stride 2

endpackage

/* src/word_ram.sv */
// word_ram
// one write port, one registered read port, word type set by parameter

`timescale 1ns/10ps

module word_ram #(
  parameter type word_t = logic [7:0],
  parameter int DEPTH = 256
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  word_t                    wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output word_t                    rdata
);

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];   // read-before-write on a collision
  end

endmodule

/* src/patch_gen.sv */
// patch_gen
// walks every output pixel and its nine kernel taps, one tap per cycle,
// and issues map and kernel read addresses with aligned tap markers

`timescale 1ns/10ps

`include "conv_config.svh"

module patch_gen (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  conv_geom_pkg::dim_t     map_dim,
  input  conv_geom_pkg::stride_t  stride,
  output conv_geom_pkg::map_addr_t map_raddr,
  output conv_geom_pkg::tap_addr_t kernel_raddr,
  output logic                    tap_valid,
  output logic                    tap_first,
  output logic                    tap_last,
  output conv_geom_pkg::map_addr_t tap_idx,
  output logic                    busy
);

  import conv_geom_pkg::*;

  localparam int KW = $clog2(`K_DIM);
  localparam tap_addr_t TAP_LAST = tap_addr_t'(`K_DIM * `K_DIM - 1);
  // last tap issue -> ram -> mac -> result write
  localparam logic [1:0] DRAIN = 2'd3;

  dim_t      dim_q;
  stride_t   stride_q;
  dim_t      out_dim;
  dim_t      orow;
  dim_t      ocol;
  logic [KW-1:0] ki;
  logic [KW-1:0] kj;
  tap_addr_t tap_cnt;
  map_addr_t pix_idx;
  logic      issuing;
  logic [1:0] drain_cnt;

  logic      last_tap;
  logic      last_pix;
  map_addr_t row_pos;
  map_addr_t col_pos;

  assign last_tap = (tap_cnt == TAP_LAST);
  assign last_pix = (orow == out_dim - dim_t'(1)) && (ocol == out_dim - dim_t'(1));

  // (row*s + ki)*map_dim + col*s + kj
  always_comb begin
    row_pos = (map_addr_t'(orow) << stride_q) + map_addr_t'(ki);
    col_pos = (map_addr_t'(ocol) << stride_q) + map_addr_t'(kj);
  end

  assign map_raddr    = row_pos * map_addr_t'(dim_q) + col_pos;
  assign kernel_raddr = tap_cnt;   // row-major kernel

  // --------------------
  // counters and run control
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy      <= 1'b0;
      issuing   <= 1'b0;
      drain_cnt <= '0;
      dim_q     <= '0;
      stride_q  <= 1'b0;
      out_dim   <= '0;
      orow      <= '0;
      ocol      <= '0;
      ki        <= '0;
      kj        <= '0;
      tap_cnt   <= '0;
      pix_idx   <= '0;
      tap_valid <= 1'b0;
      tap_first <= 1'b0;
      tap_last  <= 1'b0;
    end else begin
      if (start && !busy) begin
        busy     <= 1'b1;
        issuing  <= 1'b1;
        dim_q    <= map_dim;
        stride_q <= stride;
        out_dim  <= ((map_dim - dim_t'(`K_DIM)) >> stride) + dim_t'(1);
        orow     <= '0;
        ocol     <= '0;
        ki       <= '0;
        kj       <= '0;
        tap_cnt  <= '0;
        pix_idx  <= '0;
      end else if (issuing) begin
        if (kj == KW'(`K_DIM - 1)) begin
          kj <= '0;
          if (ki == KW'(`K_DIM - 1)) begin
            ki <= '0;
          end else begin
            ki <= ki + 1'b1;
          end
        end else begin
          kj <= kj + 1'b1;
        end
        if (last_tap) begin
          tap_cnt <= '0;
          pix_idx <= pix_idx + 1'b1;
          if (ocol == out_dim - dim_t'(1)) begin
            ocol <= '0;
            orow <= orow + 1'b1;
          end else begin
            ocol <= ocol + 1'b1;
          end
          if (last_pix) begin
            issuing   <= 1'b0;
            drain_cnt <= DRAIN;
          end
        end else begin
          tap_cnt <= tap_cnt + 1'b1;
        end
      end else if (busy) begin
        // let the pipeline empty so busy drops with done
        drain_cnt <= drain_cnt - 1'b1;
        if (drain_cnt == 2'd1) begin
          busy <= 1'b0;
        end
      end

      // markers follow the ram read by one cycle
      tap_valid <= issuing;
      tap_first <= issuing && (tap_cnt == '0);
      tap_last  <= issuing && last_tap;
    end
  end

  always_ff @(posedge clk) begin
    tap_idx <= pix_idx;
  end

endmodule

/* src/mac_unit.sv */
// mac_unit
// multiply-accumulate over the nine taps of one output pixel

`timescale 1ns/10ps

module mac_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     tap_valid,
  input  logic                     tap_first,
  input  logic                     tap_last,
  input  conv_geom_pkg::map_addr_t tap_idx,
  input  conv_data_pkg::pixel_t    pixel,
  input  conv_data_pkg::weight_t   weight,
  output logic                     acc_valid,
  output conv_data_pkg::acc_t      acc,
  output conv_geom_pkg::map_addr_t acc_idx,
  output logic                     acc_last
);

  import conv_data_pkg::*;

  acc_t prod;
  acc_t sum;
  acc_t next_sum;

  // sign-extend both operands before the multiply
  assign prod     = acc_t'(pixel) * acc_t'(weight);
  assign next_sum = tap_first ? prod : sum + prod;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= tap_valid && tap_last;
    end
  end

  // --------------------
  // running sum and output word
  always_ff @(posedge clk) begin
    if (tap_valid) begin
      sum <= next_sum;
      if (tap_last) begin
        acc     <= next_sum;   // next pixel may start right away
        acc_idx <= tap_idx;
      end
    end
  end

  // taps run back to back within a pass, so no tap behind
  // the final sum means the pass is over
  assign acc_last = acc_valid && !tap_valid;

endmodule

/* src/result_store.sv */
// result_store
// ReLU and clamp on each sum, write-back to the result buffer,
// running argmax over the stored values

`timescale 1ns/10ps

`include "conv_config.svh"

module result_store (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  logic                     acc_valid,
  input  logic                     acc_last,
  input  conv_data_pkg::acc_t      acc,
  input  conv_geom_pkg::map_addr_t acc_idx,
  output logic                     res_we,
  output conv_geom_pkg::map_addr_t res_waddr,
  output conv_data_pkg::pixel_t    res_wdata,
  output conv_geom_pkg::map_addr_t max_idx,
  output conv_data_pkg::pixel_t    max_val,
  output logic                     done
);

  import conv_data_pkg::*;

  pixel_t relu_val;
  logic   wr_last;
  logic   active;   // a run is in flight, later starts are ignored

  always_comb begin
    if (acc < 0) begin
      relu_val = '0;
    end else if (acc > acc_t'(`RES_MAX)) begin
      relu_val = pixel_t'(`RES_MAX);
    end else begin
      relu_val = pixel_t'(acc);
    end
  end

  // --------------------
  // write strobe and run tracking
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      res_we  <= 1'b0;
      wr_last <= 1'b0;
      done    <= 1'b0;
      active  <= 1'b0;
      max_idx <= '0;
      max_val <= '0;
    end else begin
      res_we  <= acc_valid;
      wr_last <= acc_valid && acc_last;
      done    <= res_we && wr_last;

      if (start && !active) begin
        active  <= 1'b1;
        max_idx <= '0;
        max_val <= '0;
      end else begin
        if (res_we && wr_last) begin
          active <= 1'b0;
        end
        // strictly greater keeps the lowest index on ties
        if (res_we && (res_wdata > max_val)) begin
          max_val <= res_wdata;
          max_idx <= res_waddr;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid) begin
      res_waddr <= acc_idx;
      res_wdata <= relu_val;
    end
  end

endmodule

/* src/conv_engine.sv */
// conv_engine
// single-channel 3x3 convolution with ReLU write-back and argmax

`timescale 1ns/10ps

`include "conv_config.svh"

module conv_engine (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  conv_geom_pkg::dim_t      map_dim,
  input  conv_geom_pkg::stride_t   stride,
  input  logic                     map_we,
  input  conv_geom_pkg::map_addr_t map_addr,
  input  conv_data_pkg::pixel_t    map_wdata,
  input  logic                     kernel_we,
  input  conv_geom_pkg::tap_addr_t kernel_addr,
  input  conv_data_pkg::weight_t   kernel_wdata,
  input  conv_geom_pkg::map_addr_t res_addr,
  output conv_data_pkg::pixel_t    res_rdata,
  output logic                     busy,
  output logic                     done,
  output conv_geom_pkg::map_addr_t max_idx,
  output conv_data_pkg::pixel_t    max_val
);

  import conv_data_pkg::*;
  import conv_geom_pkg::*;

  map_addr_t map_raddr;
  tap_addr_t kernel_raddr;
  pixel_t    map_rdata;
  weight_t   kernel_rdata;

  logic      tap_valid;
  logic      tap_first;
  logic      tap_last;
  map_addr_t tap_idx;

  logic      acc_valid;
  logic      acc_last;
  acc_t      acc;
  map_addr_t acc_idx;

  logic      res_we;
  map_addr_t res_waddr;
  pixel_t    res_wdata;

  // --------------------
  // input side
  word_ram #(.word_t(pixel_t), .DEPTH(`MAX_MAP_DIM * `MAX_MAP_DIM)) map_ram (
    .clk(clk), .we(map_we), .waddr(map_addr), .wdata(map_wdata),
    .raddr(map_raddr), .rdata(map_rdata)
  );

  word_ram #(.word_t(weight_t), .DEPTH(`K_DIM * `K_DIM)) kernel_ram (
    .clk(clk), .we(kernel_we), .waddr(kernel_addr), .wdata(kernel_wdata),
    .raddr(kernel_raddr), .rdata(kernel_rdata)
  );

  // --------------------
  // processing
  patch_gen patch_gen_i (
    .clk(clk), .rst(rst), .start(start), .map_dim(map_dim), .stride(stride),
    .map_raddr(map_raddr), .kernel_raddr(kernel_raddr),
    .tap_valid(tap_valid), .tap_first(tap_first), .tap_last(tap_last),
    .tap_idx(tap_idx), .busy(busy)
  );

  mac_unit mac_unit_i (
    .clk(clk), .rst(rst),
    .tap_valid(tap_valid), .tap_first(tap_first), .tap_last(tap_last),
    .tap_idx(tap_idx), .pixel(map_rdata), .weight(kernel_rdata),
    .acc_valid(acc_valid), .acc(acc), .acc_idx(acc_idx), .acc_last(acc_last)
  );

  // --------------------
  // output side
  result_store result_store_i (
    .clk(clk), .rst(rst), .start(start),
    .acc_valid(acc_valid), .acc_last(acc_last), .acc(acc), .acc_idx(acc_idx),
    .res_we(res_we), .res_waddr(res_waddr), .res_wdata(res_wdata),
    .max_idx(max_idx), .max_val(max_val), .done(done)
  );

  word_ram #(.word_t(pixel_t), .DEPTH(`MAX_MAP_DIM * `MAX_MAP_DIM)) res_ram (
    .clk(clk), .we(res_we), .waddr(res_waddr), .wdata(res_wdata),
    .raddr(res_addr), .rdata(res_rdata)   // read by the outside
  );

endmodule

/* sim/conv_tb_tasks.svh */
// conv_engine directed tests
// buffer loading, reference model, run and readback

`ifndef CONV_TB_TASKS_SVH
`define CONV_TB_TASKS_SVH

  task automatic load_buffers(input int dim);
    for (int a = 0; a < dim * dim; a++) begin
      map_we    = 1'b1;
      map_addr  = map_addr_t'(a);
      map_wdata = pixel_t'(map_img[a]);
      @(posedge clk);
      #1;
    end
    map_we = 1'b0;
    for (int t = 0; t < `K_DIM * `K_DIM; t++) begin
      kernel_we    = 1'b1;
      kernel_addr  = tap_addr_t'(t);
      kernel_wdata = weight_t'(kernel_img[t]);
      @(posedge clk);
      #1;
    end
    kernel_we = 1'b0;
  endtask

  // direct 3x3 sum, relu and clamp, then first index of the max
  task automatic build_expected(input int dim, input int s);
    int sum;
    out_dim = (dim - `K_DIM) / s + 1;
    exp_max_val = 0;
    for (int r = 0; r < out_dim; r++) begin
      for (int c = 0; c < out_dim; c++) begin
        sum = 0;
        for (int i = 0; i < `K_DIM; i++) begin
          for (int j = 0; j < `K_DIM; j++) begin
            sum += kernel_img[i*`K_DIM + j] * map_img[(r*s + i)*dim + c*s + j];
          end
        end
        exp_res[r*out_dim + c] = (sum < 0) ? 0 : (sum > `RES_MAX) ? `RES_MAX : sum;
        if (exp_res[r*out_dim + c] > exp_max_val) begin
          exp_max_val = exp_res[r*out_dim + c];
        end
      end
    end
    exp_max_idx = 0;
    while (exp_res[exp_max_idx] != exp_max_val) begin
      exp_max_idx++;
    end
  endtask

  task automatic wait_done();
    while (done !== 1'b1) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic read_results();
    for (int k = 0; k < out_dim * out_dim; k++) begin
      res_addr = map_addr_t'(k);
      @(posedge clk);
      #1;
      check($sformatf("res_rdata[%0d]", k), exp_res[k], int'(res_rdata));
    end
  endtask

  // restart pulses a second start while the run is going
  task automatic run_and_check(input int dim, input int s, input bit restart);
    int done_before;
    build_expected(dim, s);
    load_buffers(dim);
    done_before = done_count;
    map_dim = dim_t'(dim);
    stride  = (s == 2);
    start   = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    if (restart) begin
      repeat (3) @(posedge clk);
      #1;
      check("busy", 1, int'(busy));
      // other geometry on the ignored start
      map_dim = dim_t'(dim - 1);
      stride  = 1'b1;
      start   = 1'b1;
      @(posedge clk);
      #1;
      start   = 1'b0;
      map_dim = dim_t'(dim);
      stride  = (s == 2);
    end
    wait_done();
    check("busy", 0, int'(busy));
    check("max_val", exp_max_val, int'(max_val));
    check("max_idx", exp_max_idx, int'(max_idx));
    read_results();
    check("done pulses", 1, done_count - done_before);
  endtask

  // --------------------
  // directed tests
  task automatic random_data(input int dim);
    for (int a = 0; a < dim * dim; a++) begin
      map_img[a] = rand_signed(8);
    end
    for (int t = 0; t < `K_DIM * `K_DIM; t++) begin
      kernel_img[t] = rand_signed(8);
    end
  endtask

  task automatic test_center_tap();
    check("busy", 0, int'(busy));
    check("done", 0, int'(done));
    check("max_idx", 0, int'(max_idx));
    check("max_val", 0, int'(max_val));
    random_data(6);
    for (int t = 0; t < 9; t++) begin
      kernel_img[t] = (t == 4) ? 1 : 0;   // center only
    end
    run_and_check(6, 1, 1'b0);
  endtask

  task automatic test_random_stride1();
    repeat (2) begin
      random_data(16);
      run_and_check(16, 1, 1'b0);
    end
  endtask

  task automatic test_stride2();
    random_data(9);
    run_and_check(9, 2, 1'b0);
    // index 16 still holds the older 16x16 result
    res_addr = map_addr_t'(16);
    @(posedge clk);
    #1;
    check("res_rdata[16]", exp_res[16], int'(res_rdata));
  endtask

  task automatic test_relu_clamp();
    for (int a = 0; a < 64; a++) begin
      map_img[a] = rand_signed(6) + 64;   // 32..95
    end
    for (int t = 0; t < 9; t++) begin
      kernel_img[t] = rand_signed(6) - 40;   // always negative
    end
    run_and_check(8, 1, 1'b0);
    check("max_idx", 0, int'(max_idx));
    for (int t = 0; t < 9; t++) begin
      kernel_img[t] = 100;
    end
    run_and_check(8, 1, 1'b0);
    check("max_val", `RES_MAX, int'(max_val));
  endtask

  // outputs 8 and 27 both see 90 at the center tap
  task automatic test_argmax_tie();
    for (int a = 0; a < 64; a++) begin
      map_img[a] = rand_signed(6);
    end
    map_img[2*8 + 3] = 90;
    map_img[5*8 + 4] = 90;
    for (int t = 0; t < 9; t++) begin
      kernel_img[t] = (t == 4) ? 1 : 0;
    end
    run_and_check(8, 1, 1'b0);
    check("max_idx", 8, int'(max_idx));
  endtask

  task automatic test_start_while_busy();
    random_data(16);
    run_and_check(16, 1, 1'b1);
    // all-zero run afterwards must restart the argmax
    for (int t = 0; t < 9; t++) begin
      kernel_img[t] = -1 - (t % 3);
    end
    for (int a = 0; a < 64; a++) begin
      map_img[a] = rand_signed(6) + 64;
    end
    run_and_check(8, 1, 1'b0);
    check("max_val", 0, int'(max_val));
    check("max_idx", 0, int'(max_idx));
  endtask

`endif

/* sim/conv_engine_tb.sv */
// conv_engine testbench
// directed runs against a reference convolution model

`timescale 1ns/10ps

`include "conv_config.svh"

module conv_engine_tb;

  import conv_data_pkg::*;
  import conv_geom_pkg::*;

  localparam int CLK_HALF = 4;
  // eight 16x16 runs of about 2.3k cycles with load and readback,
  // roughly doubled for margin
  localparam int TIMEOUT_CYCLES = 40000;
  localparam int MAP_WORDS = `MAX_MAP_DIM * `MAX_MAP_DIM;

  logic      clk;
  logic      rst;
  logic      start;
  dim_t      map_dim;
  stride_t   stride;
  logic      map_we;
  map_addr_t map_addr;
  pixel_t    map_wdata;
  logic      kernel_we;
  tap_addr_t kernel_addr;
  weight_t   kernel_wdata;
  map_addr_t res_addr;
  pixel_t    res_rdata;
  logic      busy;
  logic      done;
  map_addr_t max_idx;
  pixel_t    max_val;

  logic [31:0] lfsr;
  int cycle_count;
  int done_count;
  int error_count;

  // reference copies of the buffers and the expected results
  int map_img [MAP_WORDS];
  int kernel_img [`K_DIM * `K_DIM];
  int exp_res [MAP_WORDS];
  int exp_max_val;
  int exp_max_idx;
  int out_dim;

  conv_engine conv_engine_i (
    .clk(clk), .rst(rst), .start(start), .map_dim(map_dim), .stride(stride),
    .map_we(map_we), .map_addr(map_addr), .map_wdata(map_wdata),
    .kernel_we(kernel_we), .kernel_addr(kernel_addr), .kernel_wdata(kernel_wdata),
    .res_addr(res_addr), .res_rdata(res_rdata), .busy(busy), .done(done),
    .max_idx(max_idx), .max_val(max_val)
  );

  always #CLK_HALF clk = ~clk;

  // --------------------
  // cycle limit and done pulse count
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (done) begin
      done_count = done_count + 1;
    end
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: no finished run after %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // signed value from n fresh bits, one step per bit
  function automatic int rand_signed(int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
    return bits[n-1] ? int'(bits) - (1 << n) : int'(bits);
  endfunction

  task automatic check(input string name, input int expected, input int actual);
    if (expected !== actual) begin
      error_count++;
      $display("Fail time=%0t signal=%s expected=%0d actual=%0d",
               $time, name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  `include "conv_tb_tasks.svh"

  // --------------------
  // test sequence
  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    start        = 1'b0;
    map_dim      = '0;
    stride       = 1'b0;
    map_we       = 1'b0;
    map_addr     = '0;
    map_wdata    = '0;
    kernel_we    = 1'b0;
    kernel_addr  = '0;
    kernel_wdata = '0;
    res_addr     = '0;
    lfsr         = 32'hbe162f9a;
    cycle_count  = 0;
    done_count   = 0;
    error_count  = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    test_center_tap();
    test_random_stride1();
    test_stride2();
    test_relu_clamp();
    test_argmax_tie();
    test_start_while_busy();

    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* conv_engine.f */
+incdir+src
+incdir+sim
src/conv_data_pkg.sv
src/conv_geom_pkg.sv
src/word_ram.sv
src/patch_gen.sv
src/mac_unit.sv
src/result_store.sv
src/conv_engine.sv
sim/conv_engine_tb.sv

/* Makefile */
# Verilator build and run of the conv_engine testbench

TOP = conv_engine_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f conv_engine.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
